/* src/ifu_pkg.sv */
package ifu_pkg;

  // widths with a meaning
  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;
  typedef logic [31:0] inst_t;

  // byte address without the 8-byte line offset
  typedef logic [28:0] line_addr_t;

  typedef struct packed {
    inst_t inst;
    addr_t pc;
  } fetch_out_t;

  typedef struct packed {
    logic  valid;
    addr_t pc;
  } redirect_t;

  // axi4-lite read request
  typedef struct packed {
    logic  arvalid;
    addr_t araddr;
    logic  rready;
  } axi_rd_req_t;

  // axi4-lite read response
  typedef struct packed {
    logic       arready;
    logic       rvalid;
    word_t      rdata;
    logic [1:0] rresp;
  } axi_rd_rsp_t;

  typedef enum logic [2:0] {
    RF_IDLE,
    RF_AR0,
    RF_R0,
    RF_AR1,
    RF_R1
  } refill_state_e;

  typedef enum logic {
    FS_RUN,
    FS_WAIT_REDIR
  } fetch_state_e;

  // rv32 major opcodes
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;

  localparam inst_t INST_FENCE_I = 32'h0000_100f;

endpackage

/* src/l1i_tags.sv */
`timescale 1ns/100ps

module l1i_tags #(
  parameter int unsigned LINES = 4
) (
  input  logic           clk,
  input  logic           rst,
  input  ifu_pkg::addr_t pc_i,
  input  logic           fill_i,
  input  logic           flush_i,
  output logic           hit_o
);

  import ifu_pkg::*;

  localparam int unsigned IDX_W = $clog2(LINES);

  logic [LINES-1:0] valid_q;
  line_addr_t       tag_q [LINES];

  logic [IDX_W-1:0] idx;
  line_addr_t       line_addr;

  // index sits just above the line offset
  assign idx       = pc_i[IDX_W+2:3];
  assign line_addr = pc_i[31:3];

  assign hit_o = valid_q[idx] && (tag_q[idx] == line_addr);

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (flush_i) begin
      valid_q <= '0;
    end else if (fill_i) begin
      valid_q[idx] <= 1'b1;
    end
  end

  // tag of the indexed line written by fill
  always_ff @(posedge clk) begin
    if (fill_i) begin
      tag_q[idx] <= line_addr;
    end
  end

  // the controller never refills and flushes together
  fill_flush_excl_a: assert property (
    @(posedge clk) disable iff (rst)
    !(fill_i && flush_i)
  ) else $error("fill and flush strobed in the same cycle");

endmodule

/* src/l1i_data.sv */
`timescale 1ns/100ps

module l1i_data #(
  parameter int unsigned LINES = 4
) (
  input  logic           clk,
  input  ifu_pkg::addr_t pc_i,
  input  logic           wr_en_i,
  input  logic           wr_word_i,
  input  ifu_pkg::word_t wr_data_i,
  output ifu_pkg::inst_t rd_data_o
);

  import ifu_pkg::*;

  localparam int unsigned IDX_W = $clog2(LINES);

  // two words per line with the word select in the low bit
  word_t mem_q [LINES*2];

  logic [IDX_W-1:0] idx;
  logic [IDX_W:0]   wr_addr;
  logic [IDX_W:0]   rd_addr;

  assign idx     = pc_i[IDX_W+2:3];
  assign wr_addr = {idx, wr_word_i};
  assign rd_addr = {idx, pc_i[2]};

  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      mem_q[wr_addr] <= wr_data_i;
    end
  end

  assign rd_data_o = mem_q[rd_addr];

endmodule

/* src/fetch_ctrl.sv */
`timescale 1ns/100ps

module fetch_ctrl #(
  parameter ifu_pkg::addr_t PC_INIT = 32'h8000_0000
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 hit_i,
  input  ifu_pkg::inst_t       word_i,
  output ifu_pkg::addr_t       pc_o,
  output logic                 fill_o,
  output logic                 flush_o,
  output logic                 wr_en_o,
  output logic                 wr_word_o,
  output ifu_pkg::word_t       wr_data_o,
  output ifu_pkg::axi_rd_req_t axi_req_o,
  input  ifu_pkg::axi_rd_rsp_t axi_rsp_i,
  output ifu_pkg::fetch_out_t  out_o,
  output logic                 valid_o,
  input  logic                 ready_i,
  input  ifu_pkg::redirect_t   redir_i
);

  import ifu_pkg::*;

  addr_t         pc_q;
  fetch_state_e  fs_q;
  refill_state_e rf_q;
  refill_state_e rf_d;

  logic       fire;
  logic       stop;
  logic [6:0] opcode;
  logic       beat;

  assign pc_o = pc_q;

  // lookup result is only meaningful with no refill in flight
  assign valid_o = (fs_q == FS_RUN) && (rf_q == RF_IDLE) && hit_i;
  assign fire    = valid_o && ready_i;

  assign out_o.inst = word_i;
  assign out_o.pc   = pc_q;

  // control transfers and loads wait for the back end
  assign opcode = word_i[6:0];
  assign stop   = (opcode == OP_JAL) || (opcode == OP_JALR) ||
                  (opcode == OP_BRANCH) || (opcode == OP_SYSTEM) ||
                  (opcode == OP_LOAD);

  assign flush_o = fire && (word_i == INST_FENCE_I);

  // axi read side
  assign axi_req_o.arvalid = (rf_q == RF_AR0) || (rf_q == RF_AR1);
  assign axi_req_o.rready  = (rf_q == RF_R0) || (rf_q == RF_R1);
  assign axi_req_o.araddr  = (rf_q == RF_AR1) ? {pc_q[31:3], 1'b1, pc_q[1:0]}
                                              : {pc_q[31:3], 1'b0, pc_q[1:0]};

  assign beat      = axi_req_o.rready && axi_rsp_i.rvalid;
  assign wr_en_o   = beat;
  assign wr_word_o = (rf_q == RF_R1);
  assign wr_data_o = axi_rsp_i.rdata;
  // line becomes valid on the second beat
  assign fill_o    = beat && (rf_q == RF_R1);

  always_comb begin
    rf_d = rf_q;
    unique case (rf_q)
      RF_IDLE: begin
        if (fs_q == FS_RUN && !hit_i) begin
          rf_d = RF_AR0;
        end
      end
      RF_AR0: begin
        if (axi_rsp_i.arready) begin
          rf_d = RF_R0;
        end
      end
      RF_R0: begin
        if (axi_rsp_i.rvalid) begin
          rf_d = RF_AR1;
        end
      end
      RF_AR1: begin
        if (axi_rsp_i.arready) begin
          rf_d = RF_R1;
        end
      end
      RF_R1: begin
        if (axi_rsp_i.rvalid) begin
          rf_d = RF_IDLE;
        end
      end
      default: rf_d = RF_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rf_q <= RF_IDLE;
    end else begin
      rf_q <= rf_d;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q <= PC_INIT;
      fs_q <= FS_RUN;
    end else if (fire) begin
      if (stop) begin
        fs_q <= FS_WAIT_REDIR;
      end else begin
        pc_q <= pc_q + 32'd4;
      end
    end else if (fs_q == FS_WAIT_REDIR && redir_i.valid) begin
      pc_q <= redir_i.pc;
      fs_q <= FS_RUN;
    end
  end

  // ar address must not move under a stalled request
  ar_stable_a: assert property (
    @(posedge clk) disable iff (rst)
    axi_req_o.arvalid && !axi_rsp_i.arready |=>
      axi_req_o.arvalid && $stable(axi_req_o.araddr)
  ) else $error("araddr changed while AR stalled");

  // offered instruction held until taken
  out_hold_a: assert property (
    @(posedge clk) disable iff (rst)
    valid_o && !ready_i |=> valid_o && $stable(out_o)
  ) else $error("fetch output dropped or changed without hand-off");

endmodule

/* src/ifu_top.sv */
`timescale 1ns/100ps

module ifu_top #(
  parameter int unsigned    LINES   = 4,
  parameter ifu_pkg::addr_t PC_INIT = 32'h8000_0000
) (
  input  logic                 clk,
  input  logic                 rst,
  output ifu_pkg::axi_rd_req_t axi_req_o,
  input  ifu_pkg::axi_rd_rsp_t axi_rsp_i,
  output ifu_pkg::fetch_out_t  out_o,
  output logic                 valid_o,
  input  logic                 ready_i,
  input  ifu_pkg::redirect_t   redir_i
);

  import ifu_pkg::*;

  addr_t lookup_pc;
  inst_t rd_word;
  word_t wr_data;
  logic  hit;
  logic  fill;
  logic  flush;
  logic  wr_en;
  logic  wr_word;

  l1i_tags #(
    .LINES (LINES)
  ) u_tags (
    .clk     (clk),
    .rst     (rst),
    .pc_i    (lookup_pc),
    .fill_i  (fill),
    .flush_i (flush),
    .hit_o   (hit)
  );

  l1i_data #(
    .LINES (LINES)
  ) u_data (
    .clk       (clk),
    .pc_i      (lookup_pc),
    .wr_en_i   (wr_en),
    .wr_word_i (wr_word),
    .wr_data_i (wr_data),
    .rd_data_o (rd_word)
  );

  fetch_ctrl #(
    .PC_INIT (PC_INIT)
  ) u_ctrl (
    .clk       (clk),
    .rst       (rst),
    .hit_i     (hit),
    .word_i    (rd_word),
    .pc_o      (lookup_pc),
    .fill_o    (fill),
    .flush_o   (flush),
    .wr_en_o   (wr_en),
    .wr_word_o (wr_word),
    .wr_data_o (wr_data),
    .axi_req_o (axi_req_o),
    .axi_rsp_i (axi_rsp_i),
    .out_o     (out_o),
    .valid_o   (valid_o),
    .ready_i   (ready_i),
    .redir_i   (redir_i)
  );

endmodule

/* testbench/axi_rom_model.sv */
`timescale 1ns/100ps

module axi_rom_model #(
  parameter int unsigned    WORDS = 64,
  parameter ifu_pkg::addr_t BASE  = 32'h8000_0000
) (
  input  logic                 clk,
  input  logic                 rst,
  input  ifu_pkg::axi_rd_req_t req_i,
  output ifu_pkg::axi_rd_rsp_t rsp_o,
  output logic [7:0]           ar_count_o
);

  import ifu_pkg::*;

  localparam int unsigned IDX_W = $clog2(WORDS);

  word_t      mem [WORDS];
  addr_t      addr_q;
  addr_t      fill_addr;
  logic       busy_q;
  logic       ar_rdy_q;
  logic       rvalid_q;
  logic [7:0] count_q;
  integer     seed = 32'hcbe24670;

  // filler is an addi whose immediate mixes the whole address
  initial begin
    for (int i = 0; i < WORDS; i++) begin
      fill_addr = BASE + 32'(i * 4);
      mem[i[IDX_W-1:0]] = {fill_addr[31:20] ^ fill_addr[19:8] ^ fill_addr[11:0],
                           20'h00013};
    end
  end

  always @(posedge clk) begin
    if (rst) begin
      busy_q   <= 1'b0;
      ar_rdy_q <= 1'b0;
      rvalid_q <= 1'b0;
      count_q  <= 8'd0;
    end else begin
      ar_rdy_q <= ($random(seed) & 1) != 0;
      if (req_i.arvalid && rsp_o.arready) begin
        busy_q  <= 1'b1;
        addr_q  <= req_i.araddr;
        count_q <= count_q + 8'd1;
      end
      // rvalid rises after a random delay and holds until taken
      if (busy_q && !rvalid_q) begin
        rvalid_q <= ($random(seed) & 1) != 0;
      end
      if (rvalid_q && req_i.rready) begin
        busy_q   <= 1'b0;
        rvalid_q <= 1'b0;
      end
    end
  end

  assign rsp_o.arready = ar_rdy_q && !busy_q;
  assign rsp_o.rvalid  = rvalid_q;
  assign rsp_o.rdata   = mem[addr_q[IDX_W+1:2]];
  assign rsp_o.rresp   = 2'b00;
  assign ar_count_o    = count_q;

endmodule

/* testbench/tb_ifu_top.sv */
`timescale 1ns/100ps

module tb_ifu_top;

  import ifu_pkg::*;

  localparam int unsigned LINES   = 4;
  localparam addr_t       PC_INIT = 32'h8000_0000;
  localparam int          TIMEOUT = 200;

  // rv32 words used by the program
  localparam inst_t I_ADDI  = 32'h0010_8093;
  localparam inst_t I_JAL   = 32'h0000_00ef;
  localparam inst_t I_LW    = 32'h0000_a103;
  localparam inst_t I_BEQ   = 32'h0020_8063;
  localparam inst_t I_FENCE = 32'h0000_100f;

  // one row per expected hand-off
  typedef struct packed {
    addr_t      pc;
    inst_t      inst;
    logic       redir_en;
    addr_t      redir_pc;
    // AR transfers completed before the hand-off
    logic [7:0] ars;
  } row_t;

  logic        clk;
  logic        rst;
  logic        valid_o;
  logic        ready_i;
  logic [7:0]  ar_count;
  axi_rd_req_t axi_req_o;
  axi_rd_rsp_t axi_rsp_i;
  fetch_out_t  out_o;
  redirect_t   redir_i;

  row_t       table_q [$];
  integer     seed = 32'hcbe24670;
  int         errors = 0;
  bit         done;
  bit         held;
  fetch_out_t held_out;
  addr_t      exp_araddr;

  ifu_top #(.LINES(LINES), .PC_INIT(PC_INIT)) dut0 (.*);

  axi_rom_model #(.BASE(PC_INIT)) rom0 (
    .clk        (clk),
    .rst        (rst),
    .req_i      (axi_req_o),
    .rsp_o      (axi_rsp_i),
    .ar_count_o (ar_count)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic add_row(input logic [7:0] off, input inst_t inst, input logic redir_en,
                         input logic [7:0] redir_off, input logic [7:0] ars);
    row_t r;
    r.pc       = PC_INIT + {24'd0, off};
    r.inst     = inst;
    r.redir_en = redir_en;
    r.redir_pc = PC_INIT + {24'd0, redir_off};
    r.ars      = ars;
    table_q.push_back(r);
    rom0.mem[off[7:2]] = inst;
  endtask

  initial begin
    rst     = 1'b1;
    ready_i = 1'b0;
    redir_i = '0;
    @(negedge clk);
    // loop in line 0, conflict from 0x20, then fence.i in line 1
    add_row(8'h00, I_ADDI,  1'b0, 8'h00, 8'd2);
    add_row(8'h04, I_JAL,   1'b1, 8'h00, 8'd2);
    add_row(8'h00, I_ADDI,  1'b0, 8'h00, 8'd2);
    add_row(8'h04, I_JAL,   1'b1, 8'h20, 8'd2);
    add_row(8'h20, I_LW,    1'b1, 8'h00, 8'd4);
    add_row(8'h00, I_ADDI,  1'b0, 8'h00, 8'd6);
    add_row(8'h04, I_JAL,   1'b1, 8'h08, 8'd6);
    add_row(8'h08, I_FENCE, 1'b0, 8'h00, 8'd8);
    add_row(8'h0c, I_BEQ,   1'b1, 8'h00, 8'd10);
    add_row(8'h00, I_ADDI,  1'b0, 8'h00, 8'd12);
    add_row(8'h04, I_JAL,   1'b0, 8'h00, 8'd12);
    repeat (4) @(negedge clk);
    rst = 1'b0;
    if (valid_o !== 1'b0 || axi_req_o.arvalid !== 1'b0 || axi_req_o.rready !== 1'b0) begin
      $display("ERROR valid_o arvalid rready exp 0 0 0 got %h %h %h",
               valid_o, axi_req_o.arvalid, axi_req_o.rready);
      errors++;
    end
    foreach (table_q[i]) begin
      done = 1'b0;
      held = 1'b0;
      for (int n = 0; n < TIMEOUT && !done; n++) begin
        @(negedge clk);
        // a stalled offer must hold until taken
        if (held && (!valid_o || out_o !== held_out)) begin
          $display("ERROR out_o exp %h got %h valid_o %h", held_out, out_o, valid_o);
          errors++;
        end
        // even AR count reads word 0 of the line, odd reads word 1
        exp_araddr = {table_q[i].pc[31:3], ar_count[0], 2'b00};
        if (axi_req_o.arvalid && axi_req_o.araddr !== exp_araddr) begin
          $display("ERROR araddr exp %h got %h", exp_araddr, axi_req_o.araddr);
          errors++;
        end
        ready_i  = ($random(seed) & 3) != 0;
        done     = valid_o && ready_i;
        held     = valid_o && !ready_i;
        held_out = out_o;
      end
      if (!done) begin
        $display("timed out waiting for the hand-off at pc %h", table_q[i].pc);
        errors++;
        break;
      end
      if (out_o.pc !== table_q[i].pc) begin
        $display("ERROR out_o.pc exp %h got %h", table_q[i].pc, out_o.pc);
        errors++;
      end
      if (out_o.inst !== table_q[i].inst) begin
        $display("ERROR out_o.inst exp %h got %h", table_q[i].inst, out_o.inst);
        errors++;
      end
      if (ar_count !== table_q[i].ars) begin
        $display("ERROR ar_count exp %h got %h", table_q[i].ars, ar_count);
        errors++;
      end
      if (table_q[i].redir_en) begin
        repeat (3) begin
          @(negedge clk);
          ready_i = 1'b0;
          if (valid_o !== 1'b0) begin
            $display("ERROR valid_o exp 0 got %h before the redirect to %h",
                     valid_o, table_q[i].redir_pc);
            errors++;
          end
        end
        redir_i.valid = 1'b1;
        redir_i.pc    = table_q[i].redir_pc;
        @(negedge clk);
        redir_i.valid = 1'b0;
      end
    end
    @(negedge clk);
    $display("run finished with %0d errors", errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* ifu_top.f */
src/ifu_pkg.sv
src/l1i_tags.sv
src/l1i_data.sv
src/fetch_ctrl.sv
src/ifu_top.sv
testbench/axi_rom_model.sv
testbench/tb_ifu_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Mdir obj_dir --top-module tb_ifu_top -f ifu_top.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out="$(./obj_dir/Vtb_ifu_top)"
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "All tests passed" <<< "$out"; then
  exit 0
fi
exit 1
